//--- source/sdmac_cfg.svh
// SCSI DMA datapath configuration limits for bus widths and handshake timing
`ifndef SDMAC_CFG_SVH
`define SDMAC_CFG_SVH

`default_nettype none

// Width of the CPU bus, the FIFO ports and the register file read port
`define SDMAC_DATA_WIDTH 32

// Width of the SCSI data port
// A CPU or FIFO word carries exactly two of these half-words
`define SDMAC_SCSI_WIDTH 16

// Upper bound in clock cycles on any single handshake edge
// The host model gives up waiting for req or ack after this many cycles
// and reports which edge was missing
`define SDMAC_TIMEOUT_CYCLES 50

`default_nettype wire

`endif

//--- source/sdmacPkg.sv
// SCSI DMA datapath shared types for routing commands, decode states and data words
`include "sdmac_cfg.svh"

`default_nettype none

package sdmacPkg;

    // Routing command issued by the host for one transfer
    // Each value names the source and the destination of the move
    typedef enum logic [2:0] {
        opCpuToScsi  = 3'd0,
        opScsiToCpu  = 3'd1,
        opScsiToFifo = 3'd2,
        opFifoToScsi = 3'd3,
        opFifoToCpu  = 3'd4,
        opRegToCpu   = 3'd5,
        opCpuToFifo  = 3'd6
    } routeOp;

    // States of the four-phase handshake sequencer
    // stHold keeps ack high until the host drops req
    typedef enum logic [1:0] {
        stIdle    = 2'd0,
        stExecute = 2'd1,
        stResult  = 2'd2,
        stHold    = 2'd3
    } decodeState;

    // Word on the CPU bus, the FIFO and the register file
    typedef logic [`SDMAC_DATA_WIDTH-1:0] dataWord;

    // Half-word on the SCSI data port
    typedef logic [`SDMAC_SCSI_WIDTH-1:0] scsiWord;

endpackage

`default_nettype wire

//--- source/transferDecode.sv
// Decode stage that runs the req/ack handshake and sequences execute and result
`timescale 1ns/1ps
`default_nettype none

module transferDecode (
    input  wire              CLK,
    input  wire              reset,
    input  wire              req,
    input  sdmacPkg::routeOp op,
    input  wire              halfSelect,
    output logic             ack,
    output logic             execStrobe,
    output logic             resultStrobe,
    output logic             holdActive,
    output sdmacPkg::routeOp curOp,
    output logic             curHalf
);

    sdmacPkg::decodeState state;
    sdmacPkg::decodeState nextState;

    // Only one command is in flight, so the sequence is strictly linear
    // A new req is only honoured from stIdle
    always_comb begin
        nextState = state;
        case (state)
            sdmacPkg::stIdle: begin
                if (req) begin
                    nextState = sdmacPkg::stExecute;
                end
            end
            sdmacPkg::stExecute: begin
                nextState = sdmacPkg::stResult;
            end
            sdmacPkg::stResult: begin
                nextState = sdmacPkg::stHold;
            end
            sdmacPkg::stHold: begin
                // Back-pressure keeps us here as long as the host holds req
                if (!req) begin
                    nextState = sdmacPkg::stIdle;
                end
            end
            default: begin
                nextState = sdmacPkg::stIdle;
            end
        endcase
    end

    // Strobes and ack are registered from the next state
    // so each one lines up with the state it belongs to
    always_ff @(posedge CLK) begin
        if (reset) begin
            state        <= sdmacPkg::stIdle;
            execStrobe   <= 1'b0;
            resultStrobe <= 1'b0;
            ack          <= 1'b0;
        end else begin
            state        <= nextState;
            execStrobe   <= (nextState == sdmacPkg::stExecute);
            resultStrobe <= (nextState == sdmacPkg::stResult);
            ack          <= (nextState == sdmacPkg::stHold);
        end
    end

    // The command is captured on the accepting edge
    // The host is then free to change op and halfSelect
    always_ff @(posedge CLK) begin
        if (state == sdmacPkg::stIdle && req) begin
            curOp   <= op;
            curHalf <= halfSelect;
        end
    end

    // Result stage uses this to gate the CPU output enable
    assign holdActive = (state == sdmacPkg::stHold);

    // A rising ack must answer a req that is still being held
    ackNeedsReq: assert property (
        @(posedge CLK) disable iff (reset) $rose(ack) |-> req
    );

    // The execute stage must see exactly one strobe per command
    execSinglePulse: assert property (
        @(posedge CLK) disable iff (reset) execStrobe |=> !execStrobe
    );

endmodule

`default_nettype wire

//--- source/cpuInputLatch.sv
// Execute stage latch that captures CPU write data per 16-bit lane
`include "sdmac_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module cpuInputLatch (
    input  wire               CLK,
    input  wire               reset,
    input  wire               execStrobe,
    input  sdmacPkg::routeOp  curOp,
    input  sdmacPkg::dataWord cpuDataIn,
    input  wire               laneHighEn,
    input  wire               laneLowEn,
    output sdmacPkg::dataWord cpuWord
);

    logic isCpuWrite;
    logic loadHigh;
    logic loadLow;

    // Only the two CPU write commands touch this latch
    assign isCpuWrite = (curOp == sdmacPkg::opCpuToScsi) ||
                        (curOp == sdmacPkg::opCpuToFifo);

    assign loadHigh = execStrobe && isCpuWrite && laneHighEn;

    // A CPU to SCSI move always needs the low lane, whatever its enable says
    assign loadLow  = execStrobe && isCpuWrite &&
                      (laneLowEn || curOp == sdmacPkg::opCpuToScsi);

    // Each lane has its own load, and an unloaded lane keeps its old value
    always_ff @(posedge CLK) begin
        if (reset) begin
            cpuWord <= '0;
        end else begin
            if (loadHigh) begin
                cpuWord[`SDMAC_DATA_WIDTH-1:`SDMAC_SCSI_WIDTH] <=
                    cpuDataIn[`SDMAC_DATA_WIDTH-1:`SDMAC_SCSI_WIDTH];
            end
            if (loadLow) begin
                cpuWord[`SDMAC_SCSI_WIDTH-1:0] <= cpuDataIn[`SDMAC_SCSI_WIDTH-1:0];
            end
        end
    end

    // Latched CPU data moves only on the edge that carries the execute strobe
    cpuWordQuiet: assert property (
        @(posedge CLK) disable iff (reset) !execStrobe |=> $stable(cpuWord)
    );

endmodule

`default_nettype wire

//--- source/scsiWordSteer.sv
// Execute stage that packs SCSI half-words and steers a word half onto the SCSI port
`include "sdmac_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module scsiWordSteer (
    input  wire               CLK,
    input  wire               reset,
    input  wire               execStrobe,
    input  sdmacPkg::routeOp  curOp,
    input  wire               curHalf,
    input  sdmacPkg::scsiWord pdIn,
    input  sdmacPkg::dataWord cpuWord,
    input  sdmacPkg::dataWord fifoOd,
    output sdmacPkg::scsiWord pdOut,
    output sdmacPkg::dataWord scsiPacked
);

    sdmacPkg::scsiWord cpuHalf;
    sdmacPkg::scsiWord fifoHalf;

    // Half-word selection stands in for the old A3 address line
    // A set curHalf picks the upper half of the source word
    assign cpuHalf  = curHalf ? cpuWord[`SDMAC_DATA_WIDTH-1:`SDMAC_SCSI_WIDTH]
                              : cpuWord[`SDMAC_SCSI_WIDTH-1:0];
    assign fifoHalf = curHalf ? fifoOd[`SDMAC_DATA_WIDTH-1:`SDMAC_SCSI_WIDTH]
                              : fifoOd[`SDMAC_SCSI_WIDTH-1:0];

    // Incoming SCSI data is packed one half at a time
    // Two commands with opposite halves build one full word
    always_ff @(posedge CLK) begin
        if (reset) begin
            scsiPacked <= '0;
        end else if (execStrobe) begin
            case (curOp)
                sdmacPkg::opScsiToCpu,
                sdmacPkg::opScsiToFifo: begin
                    if (curHalf) begin
                        scsiPacked[`SDMAC_DATA_WIDTH-1:`SDMAC_SCSI_WIDTH] <= pdIn;
                    end else begin
                        scsiPacked[`SDMAC_SCSI_WIDTH-1:0] <= pdIn;
                    end
                end
                default: begin
                    scsiPacked <= scsiPacked;
                end
            endcase
        end
    end

    // Outgoing SCSI data comes from the CPU latch or straight from the FIFO
    // The port holds its last value for every other command
    always_ff @(posedge CLK) begin
        if (reset) begin
            pdOut <= '0;
        end else if (execStrobe) begin
            case (curOp)
                sdmacPkg::opCpuToScsi: begin
                    pdOut <= cpuHalf;
                end
                sdmacPkg::opFifoToScsi: begin
                    pdOut <= fifoHalf;
                end
                default: begin
                    pdOut <= pdOut;
                end
            endcase
        end
    end

    // The SCSI port must not glitch between commands
    // since the target may sample it at any time
    pdOutQuiet: assert property (
        @(posedge CLK) disable iff (reset) !execStrobe |=> $stable(pdOut)
    );

endmodule

`default_nettype wire

//--- source/cpuOutputMux.sv
// Result stage that registers CPU read data, FIFO input data and the CPU output enable
`timescale 1ns/1ps
`default_nettype none

module cpuOutputMux (
    input  wire               CLK,
    input  wire               reset,
    input  wire               resultStrobe,
    input  wire               holdActive,
    input  sdmacPkg::routeOp  curOp,
    input  sdmacPkg::dataWord scsiPacked,
    input  sdmacPkg::dataWord cpuWord,
    input  sdmacPkg::dataWord fifoOd,
    input  sdmacPkg::dataWord regOd,
    output sdmacPkg::dataWord cpuDataOut,
    output sdmacPkg::dataWord fifoId,
    output logic              cpuDataOe
);

    logic isCpuRead;
    logic heldRead;

    // These are the commands where the datapath drives the CPU bus
    assign isCpuRead = (curOp == sdmacPkg::opScsiToCpu) ||
                       (curOp == sdmacPkg::opFifoToCpu) ||
                       (curOp == sdmacPkg::opRegToCpu);

    always_ff @(posedge CLK) begin
        if (reset) begin
            cpuDataOut <= '0;
            fifoId     <= '0;
            heldRead   <= 1'b0;
        end else if (resultStrobe) begin
            heldRead <= isCpuRead;
            case (curOp)
                sdmacPkg::opScsiToCpu:  cpuDataOut <= scsiPacked;
                sdmacPkg::opFifoToCpu:  cpuDataOut <= fifoOd;
                sdmacPkg::opRegToCpu:   cpuDataOut <= regOd;
                // FIFO input picks between packed SCSI data and latched CPU data
                sdmacPkg::opScsiToFifo: fifoId     <= scsiPacked;
                sdmacPkg::opCpuToFifo:  fifoId     <= cpuWord;
                default: begin
                    cpuDataOut <= cpuDataOut;
                    fifoId     <= fifoId;
                end
            endcase
        end
    end

    // The bus is only driven while the host is still looking at the result
    // and the held command was a read
    assign cpuDataOe = holdActive && heldRead;

endmodule

`default_nettype wire

//--- source/datapath.sv
// SCSI DMA datapath top that joins the decode, execute and result stages
`timescale 1ns/1ps
`default_nettype none

module datapath (
    input  wire               CLK,
    input  wire               reset,
    input  wire               req,
    output logic              ack,
    input  sdmacPkg::routeOp  op,
    input  wire               halfSelect,
    input  sdmacPkg::dataWord cpuDataIn,
    input  wire               laneHighEn,
    input  wire               laneLowEn,
    input  sdmacPkg::scsiWord pdIn,
    input  sdmacPkg::dataWord fifoOd,
    input  sdmacPkg::dataWord regOd,
    output sdmacPkg::scsiWord pdOut,
    output sdmacPkg::dataWord fifoId,
    output sdmacPkg::dataWord cpuDataOut,
    output logic              cpuDataOe
);

    logic              execStrobe;
    logic              resultStrobe;
    logic              holdActive;
    sdmacPkg::routeOp  curOp;
    logic              curHalf;
    sdmacPkg::dataWord cpuWord;
    sdmacPkg::dataWord scsiPacked;

    // Decode stage owns the handshake and the captured command
    transferDecode uDecode (
        .CLK          (CLK),
        .reset        (reset),
        .req          (req),
        .op           (op),
        .halfSelect   (halfSelect),
        .ack          (ack),
        .execStrobe   (execStrobe),
        .resultStrobe (resultStrobe),
        .holdActive   (holdActive),
        .curOp        (curOp),
        .curHalf      (curHalf)
    );

    // CPU write data is latched here before it goes to SCSI or the FIFO
    cpuInputLatch uCpuIn (
        .CLK        (CLK),
        .reset      (reset),
        .execStrobe (execStrobe),
        .curOp      (curOp),
        .cpuDataIn  (cpuDataIn),
        .laneHighEn (laneHighEn),
        .laneLowEn  (laneLowEn),
        .cpuWord    (cpuWord)
    );

    scsiWordSteer uScsi (
        .CLK        (CLK),
        .reset      (reset),
        .execStrobe (execStrobe),
        .curOp      (curOp),
        .curHalf    (curHalf),
        .pdIn       (pdIn),
        .cpuWord    (cpuWord),
        .fifoOd     (fifoOd),
        .pdOut      (pdOut),
        .scsiPacked (scsiPacked)
    );

    // Result stage drives the CPU bus and the FIFO input
    cpuOutputMux uCpuOut (
        .CLK          (CLK),
        .reset        (reset),
        .resultStrobe (resultStrobe),
        .holdActive   (holdActive),
        .curOp        (curOp),
        .scsiPacked   (scsiPacked),
        .cpuWord      (cpuWord),
        .fifoOd       (fifoOd),
        .regOd        (regOd),
        .cpuDataOut   (cpuDataOut),
        .fifoId       (fifoId),
        .cpuDataOe    (cpuDataOe)
    );

endmodule

`default_nettype wire

//--- tests/datapathTb.sv
// Table-driven testbench that drives the SCSI DMA datapath over its req/ack handshake
`include "sdmac_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module datapathTb;

    localparam int NumEntries = 16;

    // One command with its stimulus and the values expected while ack is high
    typedef struct packed {
        sdmacPkg::routeOp  op;
        logic              half;
        sdmacPkg::dataWord cpuData;
        logic              laneHigh;
        logic              laneLow;
        sdmacPkg::scsiWord pd;
        sdmacPkg::dataWord fifoData;
        sdmacPkg::dataWord regData;
        sdmacPkg::scsiWord expPdOut;
        sdmacPkg::dataWord expFifoId;
        sdmacPkg::dataWord expCpuOut;
        logic              expOe;
    } tableEntry;

    logic              CLK;
    logic              reset;
    logic              req;
    logic              ack;
    sdmacPkg::routeOp  op;
    logic              halfSelect;
    sdmacPkg::dataWord cpuDataIn;
    logic              laneHighEn;
    logic              laneLowEn;
    sdmacPkg::scsiWord pdIn;
    sdmacPkg::dataWord fifoOd;
    sdmacPkg::dataWord regOd;
    sdmacPkg::scsiWord pdOut;
    sdmacPkg::dataWord fifoId;
    sdmacPkg::dataWord cpuDataOut;
    logic              cpuDataOe;

    tableEntry entries [NumEntries];
    integer    seed;

    datapath dut_i (
        .CLK        (CLK),
        .reset      (reset),
        .req        (req),
        .ack        (ack),
        .op         (op),
        .halfSelect (halfSelect),
        .cpuDataIn  (cpuDataIn),
        .laneHighEn (laneHighEn),
        .laneLowEn  (laneLowEn),
        .pdIn       (pdIn),
        .fifoOd     (fifoOd),
        .regOd      (regOd),
        .pdOut      (pdOut),
        .fifoId     (fifoId),
        .cpuDataOut (cpuDataOut),
        .cpuDataOe  (cpuDataOe)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkWord(input string name, input sdmacPkg::dataWord expected,
                             input sdmacPkg::dataWord actual);
        if (actual !== expected) begin
            abortRun($sformatf("MISMATCH %s expected 0x%08h actual 0x%08h",
                               name, expected, actual));
        end
    endtask

    task automatic checkHalf(input string name, input sdmacPkg::scsiWord expected,
                             input sdmacPkg::scsiWord actual);
        if (actual !== expected) begin
            abortRun($sformatf("MISMATCH %s expected 0x%04h actual 0x%04h",
                               name, expected, actual));
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abortRun($sformatf("MISMATCH %s expected 0x%1h actual 0x%1h",
                               name, expected, actual));
        end
    endtask

    // Polls ack on falling edges, where it is stable, until it reaches the wanted level
    task automatic waitForAck(input logic level, input string edgeName);
        int cycles;
        cycles = 0;
        while (ack !== level && cycles < `SDMAC_TIMEOUT_CYCLES) begin
            @(negedge CLK);
            cycles++;
        end
        if (ack !== level) begin
            abortRun($sformatf("Timeout: the datapath never showed %s", edgeName));
        end
    endtask

    task automatic setEntry(input int idx, input sdmacPkg::routeOp entryOp,
                            input logic entryHalf, input sdmacPkg::dataWord entryCpu,
                            input logic entryHigh, input logic entryLow,
                            input sdmacPkg::scsiWord entryPd);
        entries[idx]          = '0;
        entries[idx].op       = entryOp;
        entries[idx].half     = entryHalf;
        entries[idx].cpuData  = entryCpu;
        entries[idx].laneHigh = entryHigh;
        entries[idx].laneLow  = entryLow;
        entries[idx].pd       = entryPd;
        // FIFO and register words are random so that each read sees fresh data
        entries[idx].fifoData = $random(seed);
        entries[idx].regData  = $random(seed);
    endtask

    function automatic sdmacPkg::scsiWord selectHalf(input sdmacPkg::dataWord word,
                                                     input logic upper);
        if (upper) begin
            return word[`SDMAC_DATA_WIDTH-1:`SDMAC_SCSI_WIDTH];
        end
        return word[`SDMAC_SCSI_WIDTH-1:0];
    endfunction

    task automatic fillTable();
        // CPU to SCSI where the second write has both lane enables clear
        setEntry(0, sdmacPkg::opCpuToScsi, 1'b0, 32'hA1B2C3D4, 1'b1, 1'b0, 16'h0000);
        setEntry(1, sdmacPkg::opCpuToScsi, 1'b1, 32'h11223344, 1'b0, 1'b0, 16'h0000);
        setEntry(2, sdmacPkg::opCpuToScsi, 1'b0, 32'h55667788, 1'b1, 1'b0, 16'h0000);
        // SCSI half-words packed into the FIFO word and then into the CPU word
        setEntry(3, sdmacPkg::opScsiToFifo, 1'b0, 32'h0, 1'b0, 1'b0, 16'hBEEF);
        setEntry(4, sdmacPkg::opScsiToFifo, 1'b1, 32'h0, 1'b0, 1'b0, 16'hDEAD);
        setEntry(5, sdmacPkg::opScsiToCpu, 1'b1, 32'h0, 1'b0, 1'b0, 16'hCAFE);
        setEntry(6, sdmacPkg::opScsiToCpu, 1'b0, 32'h0, 1'b0, 1'b0, 16'hF00D);
        // CPU reads from the FIFO and the register file
        setEntry(7, sdmacPkg::opFifoToCpu, 1'b0, 32'h0, 1'b0, 1'b0, 16'h0000);
        setEntry(8, sdmacPkg::opRegToCpu, 1'b0, 32'h0, 1'b0, 1'b0, 16'h0000);
        // CPU to FIFO with one lane at a time after a full write
        setEntry(9, sdmacPkg::opCpuToFifo, 1'b0, 32'h12345678, 1'b1, 1'b1, 16'h0000);
        setEntry(10, sdmacPkg::opCpuToFifo, 1'b0, 32'hAAAABBBB, 1'b0, 1'b1, 16'h0000);
        setEntry(11, sdmacPkg::opCpuToFifo, 1'b0, 32'hCCCCDDDD, 1'b1, 1'b0, 16'h0000);
        // FIFO to SCSI followed by reads that must leave pdOut untouched
        setEntry(12, sdmacPkg::opFifoToScsi, 1'b1, 32'h0, 1'b0, 1'b0, 16'h0000);
        setEntry(13, sdmacPkg::opFifoToCpu, 1'b0, 32'h0, 1'b0, 1'b0, 16'h0000);
        setEntry(14, sdmacPkg::opRegToCpu, 1'b1, 32'h0, 1'b0, 1'b0, 16'h0000);
        setEntry(15, sdmacPkg::opFifoToScsi, 1'b0, 32'h0, 1'b0, 1'b0, 16'h0000);
    endtask

    // Reference model of the routing rules that runs over the whole table in order
    task automatic buildExpected();
        sdmacPkg::dataWord modelCpuWord;
        sdmacPkg::dataWord modelPacked;
        sdmacPkg::scsiWord modelPdOut;
        sdmacPkg::dataWord modelFifoId;
        sdmacPkg::dataWord modelCpuOut;
        sdmacPkg::routeOp  entryOp;
        int                i;
        modelCpuWord = '0;
        modelPacked  = '0;
        modelPdOut   = '0;
        modelFifoId  = '0;
        modelCpuOut  = '0;
        for (i = 0; i < NumEntries; i++) begin
            entryOp = entries[i].op;
            // pdOut and the CPU latch load on the same strobe edge
            // so the SCSI port carries the word from the write before
            if (entryOp == sdmacPkg::opCpuToScsi) begin
                modelPdOut = selectHalf(modelCpuWord, entries[i].half);
            end
            if (entryOp == sdmacPkg::opFifoToScsi) begin
                modelPdOut = selectHalf(entries[i].fifoData, entries[i].half);
            end
            if (entryOp == sdmacPkg::opCpuToScsi || entryOp == sdmacPkg::opCpuToFifo) begin
                if (entries[i].laneHigh) begin
                    modelCpuWord[31:16] = entries[i].cpuData[31:16];
                end
                if (entries[i].laneLow || entryOp == sdmacPkg::opCpuToScsi) begin
                    modelCpuWord[15:0] = entries[i].cpuData[15:0];
                end
            end
            if (entryOp == sdmacPkg::opScsiToCpu || entryOp == sdmacPkg::opScsiToFifo) begin
                if (entries[i].half) begin
                    modelPacked[31:16] = entries[i].pd;
                end else begin
                    modelPacked[15:0] = entries[i].pd;
                end
            end
            // The result stage sees what the execute stage produced one edge earlier
            case (entryOp)
                sdmacPkg::opScsiToCpu:  modelCpuOut = modelPacked;
                sdmacPkg::opFifoToCpu:  modelCpuOut = entries[i].fifoData;
                sdmacPkg::opRegToCpu:   modelCpuOut = entries[i].regData;
                sdmacPkg::opScsiToFifo: modelFifoId = modelPacked;
                sdmacPkg::opCpuToFifo:  modelFifoId = modelCpuWord;
                default: begin
                end
            endcase
            entries[i].expPdOut  = modelPdOut;
            entries[i].expFifoId = modelFifoId;
            entries[i].expCpuOut = modelCpuOut;
            entries[i].expOe     = (entryOp == sdmacPkg::opScsiToCpu) ||
                                   (entryOp == sdmacPkg::opFifoToCpu) ||
                                   (entryOp == sdmacPkg::opRegToCpu);
        end
    endtask

    task automatic checkOutputs(input int idx);
        checkHalf("pdOut", entries[idx].expPdOut, pdOut);
        checkWord("fifoId", entries[idx].expFifoId, fifoId);
        checkWord("cpuDataOut", entries[idx].expCpuOut, cpuDataOut);
        checkFlag("cpuDataOe", entries[idx].expOe, cpuDataOe);
    endtask

    initial begin
        int idx;
        seed       = 59;
        reset      = 1'b1;
        req        = 1'b0;
        op         = sdmacPkg::opCpuToScsi;
        halfSelect = 1'b0;
        cpuDataIn  = '0;
        laneHighEn = 1'b0;
        laneLowEn  = 1'b0;
        pdIn       = '0;
        fifoOd     = '0;
        regOd      = '0;
        fillTable();
        buildExpected();

        repeat (2) @(posedge CLK);
        @(negedge CLK);
        reset = 1'b0;

        // Everything visible to the host must come out of reset idle and zero
        checkFlag("ack", 1'b0, ack);
        checkFlag("cpuDataOe", 1'b0, cpuDataOe);
        checkHalf("pdOut", '0, pdOut);
        checkWord("fifoId", '0, fifoId);
        checkWord("cpuDataOut", '0, cpuDataOut);

        for (idx = 0; idx < NumEntries; idx++) begin
            op         = entries[idx].op;
            halfSelect = entries[idx].half;
            cpuDataIn  = entries[idx].cpuData;
            laneHighEn = entries[idx].laneHigh;
            laneLowEn  = entries[idx].laneLow;
            pdIn       = entries[idx].pd;
            fifoOd     = entries[idx].fifoData;
            regOd      = entries[idx].regData;
            req        = 1'b1;
            waitForAck(1'b1, "ack rising after req");
            checkOutputs(idx);
            // Host holds req one more cycle and the results must not move
            @(negedge CLK);
            checkFlag("ack", 1'b1, ack);
            checkOutputs(idx);
            req = 1'b0;
            waitForAck(1'b0, "ack falling after req dropped");
            checkFlag("cpuDataOe", 1'b0, cpuDataOe);
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+source
source/sdmacPkg.sv
source/transferDecode.sv
source/cpuInputLatch.sv
source/scsiWordSteer.sv
source/cpuOutputMux.sv
source/datapath.sv
tests/datapathTb.sv

//--- run.sh
#!/bin/sh
# Build and run the datapath testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f flist.f --top-module datapathTb -o simDatapath

# The simulator output goes to the log, and the log decides the result
./obj_dir/simDatapath 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
    exit 1
fi
exit 0
